/* hdl/vscroll_macros.svh */
// Register map and field widths of the scroll block
// Offsets are 9-bit byte offsets inside the region at address bits 11:9
`ifndef VSCROLL_MACROS_SVH
`define VSCROLL_MACROS_SVH

// Page select, flip and non-flip sets
`define SCR_OFS_S1_PG_FLIP  9'h08E
`define SCR_OFS_S1_PG_NOFL  9'h09E
`define SCR_OFS_S2_PG_FLIP  9'h08C
`define SCR_OFS_S2_PG_NOFL  9'h09C

// Scroll positions
`define SCR_OFS_S1_VPOS     9'h124
`define SCR_OFS_S2_VPOS     9'h126
`define SCR_OFS_S1_HPOS     9'h1F8
`define SCR_OFS_S2_HPOS     9'h1FA

`define SCR_REGION          3'b111  // Matched against address bits 11:9

`define SCR_ADDR_W          12      // Host byte address
`define TILE_ADDR_W         14
`define BEAM_H_W            10
`define BEAM_V_W            9

`endif

/* hdl/vscroll_pkg.sv */
// Shared types of the scroll subsystem
// Field widths come from the macros header
`include "vscroll_macros.svh"

package vscroll_pkg;

    // One halfword access from the bus front end
    typedef struct packed {
        logic                       wr;     // Write strobe, one cycle
        logic [`SCR_ADDR_W-1:1]     addr;   // Halfword address
        logic [15:0]                data;
        logic [1:0]                 be;     // Active-high byte enables
    } mmr_req_t;

    // Display copy of one layer
    typedef struct packed {
        logic [15:0] pages;                 // Four page nibbles
        logic [15:0] hpos;
        logic [15:0] vpos;
    } layer_scroll_t;

    typedef struct packed {
        logic                   valid;
        logic [`BEAM_H_W-1:0]   h;
        logic [`BEAM_V_W-1:0]   v;
    } beam_pos_t;

    typedef struct packed {
        logic                       valid;
        logic [`TILE_ADDR_W-1:0]    addr;
        logic [2:0]                 fine_x;
        logic [2:0]                 fine_y;
    } tile_req_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRESP,   // Holding bvalid
        ST_RRESP    // Holding rvalid
    } axil_state_e;

endpackage

/* hdl/axil_mmr_slave.sv */
// AXI4-Lite front end for the halfword register bank, one transfer at a time
// Writes need AW and W valid together; writes win over reads
`timescale 1ns/1ps
`include "vscroll_macros.svh"

module axil_mmr_slave
    import vscroll_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,

    // Write channels
    input  logic [`SCR_ADDR_W-1:0]  awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,

    // Read channels
    input  logic [`SCR_ADDR_W-1:0]  araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,

    // Register bank side
    output mmr_req_t                req,
    input  logic [15:0]             rd_data
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    axil_state_e state;
    axil_state_e state_nxt;
    logic        wr_hs;
    logic        rd_hs;
    logic        aw_in_region;
    logic        ar_in_region;

    assign aw_in_region = awaddr[`SCR_ADDR_W-1 -: 3] == `SCR_REGION;
    assign ar_in_region = araddr[`SCR_ADDR_W-1 -: 3] == `SCR_REGION;

    // Address channels only open in idle and out of reset
    assign awready = arst_n && (state == ST_IDLE) && awvalid && wvalid;
    assign wready  = awready;
    assign arready = arst_n && (state == ST_IDLE) && arvalid && !(awvalid && wvalid);

    assign wr_hs = awvalid && awready;
    assign rd_hs = arvalid && arready;

    assign bvalid = state == ST_WRESP;
    assign rvalid = state == ST_RRESP;

    // Bank request, lane picked by address bit 1
    always_comb begin
        req.wr   = wr_hs && aw_in_region;   // No write outside the region
        req.addr = wr_hs ? awaddr[`SCR_ADDR_W-1:1] : araddr[`SCR_ADDR_W-1:1];
        req.data = awaddr[1] ? wdata[31:16] : wdata[15:0];
        req.be   = awaddr[1] ? wstrb[3:2]   : wstrb[1:0];
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (wr_hs) begin
                    state_nxt = ST_WRESP;
                end else if (rd_hs) begin
                    state_nxt = ST_RRESP;
                end
            end
            ST_WRESP: if (bready) state_nxt = ST_IDLE;
            ST_RRESP: if (rready) state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Response payload, frozen while the response waits
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= aw_in_region ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_hs) begin
            rresp <= ar_in_region ? RESP_OKAY : RESP_SLVERR;
            if (!ar_in_region) begin
                rdata <= '0;
            end else if (araddr[1]) begin
                rdata <= {rd_data, 16'h0000};   // Upper lane
            end else begin
                rdata <= {16'h0000, rd_data};
            end
        end
    end

endmodule

/* hdl/scroll_mmr.sv */
// Scroll register bank with byte-lane writes
// Requests are already region-qualified, only the offset is decoded here
`timescale 1ns/1ps
`include "vscroll_macros.svh"

module scroll_mmr
    import vscroll_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flip,       // Selects the flip page set
    input  mmr_req_t        req,
    output logic [15:0]     rd_data,
    output layer_scroll_t   layer1,
    output layer_scroll_t   layer2
);

    logic [15:0] s1_pg_flip;
    logic [15:0] s1_pg_nofl;
    logic [15:0] s2_pg_flip;
    logic [15:0] s2_pg_nofl;
    logic [15:0] s1_vpos;
    logic [15:0] s2_vpos;
    logic [15:0] s1_hpos;
    logic [15:0] s2_hpos;
    logic [8:0]  ofs;

    assign ofs = {req.addr[8:1], 1'b0}; // Byte offset inside the region

    // Keep disabled bytes, take enabled ones from the request
    function automatic logic [15:0] byte_merge(input logic [15:0] old, input mmr_req_t r);
        byte_merge = {r.be[1] ? r.data[15:8] : old[15:8],
                      r.be[0] ? r.data[7:0]  : old[7:0]};
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_pg_flip <= '0;
            s1_pg_nofl <= '0;
            s2_pg_flip <= '0;
            s2_pg_nofl <= '0;
            s1_vpos    <= '0;
            s2_vpos    <= '0;
            s1_hpos    <= '0;
            s2_hpos    <= '0;
        end else if (req.wr) begin
            case (ofs)
                `SCR_OFS_S1_PG_FLIP: s1_pg_flip <= byte_merge(s1_pg_flip, req);
                `SCR_OFS_S1_PG_NOFL: s1_pg_nofl <= byte_merge(s1_pg_nofl, req);
                `SCR_OFS_S2_PG_FLIP: s2_pg_flip <= byte_merge(s2_pg_flip, req);
                `SCR_OFS_S2_PG_NOFL: s2_pg_nofl <= byte_merge(s2_pg_nofl, req);
                `SCR_OFS_S1_VPOS:    s1_vpos    <= byte_merge(s1_vpos, req);
                `SCR_OFS_S2_VPOS:    s2_vpos    <= byte_merge(s2_vpos, req);
                `SCR_OFS_S1_HPOS:    s1_hpos    <= byte_merge(s1_hpos, req);
                `SCR_OFS_S2_HPOS:    s2_hpos    <= byte_merge(s2_hpos, req);
                default: ;  // Unmapped offsets ignore writes
            endcase
        end
    end

    // Display copies, pages follow flip
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            layer1 <= '0;
            layer2 <= '0;
        end else begin
            layer1.pages <= flip ? s1_pg_flip : s1_pg_nofl;
            layer1.hpos  <= s1_hpos;
            layer1.vpos  <= s1_vpos;
            layer2.pages <= flip ? s2_pg_flip : s2_pg_nofl;
            layer2.hpos  <= s2_hpos;
            layer2.vpos  <= s2_vpos;
        end
    end

    // Raw register readback
    always_comb begin
        case (ofs)
            `SCR_OFS_S1_PG_FLIP: rd_data = s1_pg_flip;
            `SCR_OFS_S1_PG_NOFL: rd_data = s1_pg_nofl;
            `SCR_OFS_S2_PG_FLIP: rd_data = s2_pg_flip;
            `SCR_OFS_S2_PG_NOFL: rd_data = s2_pg_nofl;
            `SCR_OFS_S1_VPOS:    rd_data = s1_vpos;
            `SCR_OFS_S2_VPOS:    rd_data = s2_vpos;
            `SCR_OFS_S1_HPOS:    rd_data = s1_hpos;
            `SCR_OFS_S2_HPOS:    rd_data = s2_hpos;
            default:             rd_data = 16'h0000;
        endcase
    end

endmodule

/* hdl/tile_addr_gen.sv */
// Beam position to tilemap address for one layer, fixed 2-cycle latency
// No back-pressure; scroll is sampled together with the beam
`timescale 1ns/1ps
`include "vscroll_macros.svh"

module tile_addr_gen
    import vscroll_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  layer_scroll_t   scroll,
    input  beam_pos_t       beam,
    output tile_req_t       tile
);

    // Stage 1
    logic                   s1_valid;
    logic [`BEAM_H_W-1:0]   s1_x;
    logic [`BEAM_V_W-1:0]   s1_y;
    logic [15:0]            s1_pages;

    // Stage 2
    logic [1:0]             quad;
    logic [2:0]             page;
    logic                   s2_valid;
    logic [`TILE_ADDR_W-1:0] s2_addr;
    logic [2:0]             s2_fine_x;
    logic [2:0]             s2_fine_y;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= beam.valid;
            s2_valid <= s1_valid;
        end
    end

    // Scrolled position, wraps at the tilemap size
    always_ff @(posedge clk) begin
        s1_x     <= beam.h + scroll.hpos[`BEAM_H_W-1:0];
        s1_y     <= beam.v + scroll.vpos[`BEAM_V_W-1:0];
        s1_pages <= scroll.pages;
    end

    assign quad = {s1_y[`BEAM_V_W-1], s1_x[`BEAM_H_W-1]};   // Y half is the high bit

    always_comb begin
        case (quad)
            2'd0:    page = s1_pages[2:0];
            2'd1:    page = s1_pages[6:4];
            2'd2:    page = s1_pages[10:8];
            default: page = s1_pages[14:12];
        endcase
    end

    // Page, tile row, tile column
    always_ff @(posedge clk) begin
        s2_addr   <= {page, s1_y[`BEAM_V_W-2:3], s1_x[`BEAM_H_W-2:3]};
        s2_fine_x <= s1_x[2:0];
        s2_fine_y <= s1_y[2:0];
    end

    assign tile = '{valid:  s2_valid,
                    addr:   s2_addr,
                    fine_x: s2_fine_x,
                    fine_y: s2_fine_y};

endmodule

/* hdl/scroll_top.sv */
// Scroll control top: AXI4-Lite registers and two tile address generators
// Beam to tile latency is 2 cycles for both layers
`timescale 1ns/1ps
`include "vscroll_macros.svh"

module scroll_top
    import vscroll_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic [`SCR_ADDR_W-1:0]  awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    input  logic [`SCR_ADDR_W-1:0]  araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,

    input  logic                    flip,
    input  beam_pos_t               beam,
    output tile_req_t               tile1,
    output tile_req_t               tile2
);

    mmr_req_t       req;
    logic [15:0]    rd_data;
    layer_scroll_t  layer1;
    layer_scroll_t  layer2;

    axil_mmr_slave u_slave (
        .clk, .arst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bvalid, .bready, .bresp,
        .araddr, .arvalid, .arready, .rvalid, .rready, .rdata, .rresp,
        .req, .rd_data
    );

    scroll_mmr u_mmr (
        .clk, .arst_n, .flip, .req, .rd_data, .layer1, .layer2
    );

    tile_addr_gen u_gen1 (.clk, .arst_n, .scroll(layer1), .beam, .tile(tile1));
    tile_addr_gen u_gen2 (.clk, .arst_n, .scroll(layer2), .beam, .tile(tile2));

endmodule

/* verif/scroll_assert.sv */
// AXI4-Lite response checks, bound into every axil_mmr_slave
// Payload stability is checked only while a response waits for its ready
`timescale 1ns/1ps

module scroll_assert (
    input logic         clk,
    input logic         arst_n,
    input logic         awready,
    input logic         wready,
    input logic         arready,
    input logic         bvalid,
    input logic         bready,
    input logic [1:0]   bresp,
    input logic         rvalid,
    input logic         rready,
    input logic [31:0]  rdata,
    input logic [1:0]   rresp
);

    int n_fail = 0;     // Failure count, read by the testbench

    b_hold: assert property (@(posedge clk) disable iff (!arst_n)
                             bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            n_fail++;
            $error("write response dropped or changed before bready");
        end

    r_hold: assert property (@(posedge clk) disable iff (!arst_n)
                             rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            n_fail++;
            $error("read response dropped or changed before rready");
        end

    // Nothing accepted while in reset
    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !(awready || wready || arready))
        else begin
            n_fail++;
            $error("ready high during reset");
        end

endmodule

bind axil_mmr_slave scroll_assert u_assert (
    .clk, .arst_n, .awready, .wready, .arready, .bvalid, .bready, .bresp,
    .rvalid, .rready, .rdata, .rresp
);

/* verif/scroll_tb.sv */
// Directed and LCG-random tests of the scroll subsystem over AXI4-Lite
// Tile checks expect registers and flip to stay quiet while beams are valid
`timescale 1ns/1ps
`include "vscroll_macros.svh"

module scroll_tb
    import vscroll_pkg::*;
();

    localparam int N_FULL   = 4;    // Rounds over all eight registers
    localparam int N_PART   = 32;
    localparam int N_BAD    = 16;
    localparam int N_SCROLL = 8;
    localparam int N_BEAMS  = 24;   // Beams per scroll setting
    localparam int ACC_CYC  = 6;    // Worst AXI access, response delay included
    // All AXI accesses, then every beam run with its drain
    localparam int EST_CYC  = 16 + ACC_CYC * (13 + 16 * N_FULL + 2 * N_PART + 3 * N_BAD
                            + 8 * N_SCROLL) + (N_BEAMS + 4) * (5 + N_SCROLL);
    localparam int CYCLE_LIMIT = 2 * EST_CYC;

    localparam logic [8:0] REG_OFS [8] = '{
        `SCR_OFS_S1_PG_FLIP, `SCR_OFS_S1_PG_NOFL, `SCR_OFS_S2_PG_FLIP, `SCR_OFS_S2_PG_NOFL,
        `SCR_OFS_S1_VPOS, `SCR_OFS_S2_VPOS, `SCR_OFS_S1_HPOS, `SCR_OFS_S2_HPOS};

    logic                   clk;
    logic                   arst_n;
    logic [`SCR_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   wready;
    logic                   bvalid;
    logic                   bready;
    logic [1:0]             bresp;
    logic [`SCR_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic                   rvalid;
    logic                   rready;
    logic [31:0]            rdata;
    logic [1:0]             rresp;
    logic                   flip;
    beam_pos_t              beam;
    tile_req_t              tile1;
    tile_req_t              tile2;

    logic [15:0] shadow [8] = '{default: 16'h0000};    // Register model in REG_OFS order
    logic [31:0] lcg_state  = 32'h634f_43f7;
    tile_req_t   exp1_pipe [2];
    tile_req_t   exp2_pipe [2];
    int          cycles     = 0;
    int          n_checks   = 0;
    int          n_errors   = 0;
    int          n_tests    = 0;
    int          n_failed   = 0;
    int          test_err0  = 0;

    scroll_top dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = next_random();
        return r[31:16];    // High bits, the low ones repeat quickly
    endfunction

    function automatic int reg_index(input logic [8:0] ofs);
        int i;
        int idx;
        idx = -1;
        for (i = 0; i < 8; i++) begin
            if (REG_OFS[i] == {ofs[8:1], 1'b0}) idx = i;
        end
        return idx;
    endfunction

    function automatic logic [1:0] exp_resp(input logic [`SCR_ADDR_W-1:0] addr);
        return (addr[11:9] == `SCR_REGION) ? 2'b00 : 2'b10;    // OKAY or SLVERR
    endfunction

    function automatic logic [31:0] exp_rdata(input logic [`SCR_ADDR_W-1:0] addr);
        int          idx;
        logic [15:0] half;
        idx  = reg_index(addr[8:0]);
        half = (addr[11:9] == `SCR_REGION && idx >= 0) ? shadow[idx] : 16'h0000;
        return addr[1] ? {half, 16'h0000} : {16'h0000, half};
    endfunction

    // Lane from address bit 1, then per-byte update
    function automatic void model_write(input logic [`SCR_ADDR_W-1:0] addr,
                                        input logic [31:0] data, input logic [3:0] strb);
        int          idx;
        logic [15:0] half;
        logic [1:0]  lanes;
        idx   = reg_index(addr[8:0]);
        half  = addr[1] ? data[31:16] : data[15:0];
        lanes = addr[1] ? strb[3:2] : strb[1:0];
        if (addr[11:9] == `SCR_REGION && idx >= 0) begin
            if (lanes[0]) shadow[idx][7:0] = half[7:0];
            if (lanes[1]) shadow[idx][15:8] = half[15:8];
        end
    endfunction

    function automatic tile_req_t exp_tile(input beam_pos_t b, input int layer, input logic fl);
        logic [15:0] pages;
        logic [9:0]  x;
        logic [8:0]  y;
        logic [1:0]  quad;
        logic [2:0]  page;
        tile_req_t   t;
        // Layer 1 uses shadow 0, 1, 4, 6 and layer 2 uses 2, 3, 5, 7
        pages    = shadow[2 * (layer - 1) + (fl ? 0 : 1)];
        x        = b.h + shadow[5 + layer][9:0];
        y        = b.v + shadow[3 + layer][8:0];
        quad     = {y[8], x[9]};
        page     = pages[4 * quad +: 3];
        t.valid  = b.valid;
        t.addr   = {page, y[7:3], x[8:3]};
        t.fine_x = x[2:0];
        t.fine_y = y[2:0];
        return t;
    endfunction

    function automatic int total_errors();
        return n_errors + dut.u_slave.u_assert.n_fail;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_tile(input string name, input tile_req_t got, input tile_req_t exp);
        check_val({name, ".valid"}, got.valid, exp.valid);
        if (exp.valid) begin
            check_val({name, ".addr"}, got.addr, exp.addr);
            check_val({name, ".fine_x"}, got.fine_x, exp.fine_x);
            check_val({name, ".fine_y"}, got.fine_y, exp.fine_y);
        end
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        if (total_errors() != test_err0) n_failed++;
        $display("test %0d %s: %s, %0d errors", n_tests, name,
                 (total_errors() == test_err0) ? "ok" : "failed", total_errors() - test_err0);
        test_err0 = total_errors();
    endtask

    task automatic write_reg(input logic [`SCR_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int bdelay);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_val("bvalid", bvalid, 1'b1);      // One cycle after the transfer
        repeat (bdelay) begin
            @(posedge clk);
            #1;
        end
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        check_val("bresp", bresp, exp_resp(addr));
        model_write(addr, data, strb);
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [`SCR_ADDR_W-1:0] addr, input int rdelay);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        check_val("rvalid", rvalid, 1'b1);
        repeat (rdelay) begin
            @(posedge clk);
            #1;
        end
        rready = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        check_val("rdata", rdata, exp_rdata(addr));
        check_val("rresp", rresp, exp_resp(addr));
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic run_beams(input int n);
        logic [31:0] r;
        repeat (n) begin
            r          = next_random();
            beam.valid = r[31] | r[30];     // Mostly valid, some gaps
            beam.h     = r[29:20];
            beam.v     = r[19:11];
            @(posedge clk);
            #1;
        end
        beam.valid = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Expected tiles follow the 2-stage generator, compared mid-cycle
    always @(posedge clk) begin
        exp1_pipe[1] <= exp1_pipe[0];
        exp1_pipe[0] <= exp_tile(beam, 1, flip);
        exp2_pipe[1] <= exp2_pipe[0];
        exp2_pipe[0] <= exp_tile(beam, 2, flip);
    end

    always @(negedge clk) begin
        if (arst_n) begin
            compare_tile("tile1", tile1, exp1_pipe[1]);
            compare_tile("tile2", tile2, exp2_pipe[1]);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [`SCR_ADDR_W-1:0] addr;
        logic [31:0]            r;
        logic [15:0]            pg;
        int                     idx;
        clk     = 1'b0;
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        flip    = 1'b0;
        beam    = '0;
        repeat (6) @(posedge clk);
        #1;
        awvalid = 1'b1;     // Host requests while still in reset
        wvalid  = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        arvalid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (idx = 0; idx < 8; idx++) read_reg({`SCR_REGION, REG_OFS[idx]}, 0);
        read_reg({`SCR_REGION, 9'h000}, 0);     // Unmapped offset
        run_beams(16);
        finish_test("reset values");

        repeat (N_FULL) begin
            for (idx = 0; idx < 8; idx++) begin
                r    = next_random();
                addr = {`SCR_REGION, REG_OFS[idx][8:1], r[31]};    // Bit 0 is ignored
                write_reg(addr, {rand16(), rand16()},
                          addr[1] ? {2'b11, r[29:28]} : {r[29:28], 2'b11}, 0);
            end
            for (idx = 0; idx < 8; idx++) read_reg({`SCR_REGION, REG_OFS[idx]}, 0);
        end
        finish_test("full writes");

        repeat (N_PART) begin
            r    = next_random();
            addr = {`SCR_REGION, REG_OFS[r[18:16]]};
            write_reg(addr, {rand16(), rand16()}, r[27:24], 0);
            read_reg(addr, 0);
        end
        finish_test("partial writes");

        repeat (N_BAD) begin
            r    = next_random();
            addr = {((r[31:29] == `SCR_REGION) ? 3'b011 : r[31:29]), REG_OFS[r[18:16]]};
            write_reg(addr, {rand16(), rand16()}, 4'hf, r[2:0] % 5);
            read_reg(addr, r[5:3] % 5);
            read_reg({`SCR_REGION, addr[8:0]}, r[8:6] % 5);    // Must hold its old value
        end
        finish_test("out of region");

        repeat (N_SCROLL) begin
            r    = next_random();
            flip = r[31];
            for (idx = 0; idx < 8; idx++) begin
                write_reg({`SCR_REGION, REG_OFS[idx]}, {rand16(), rand16()}, 4'hf, 0);
            end
            run_beams(N_BEAMS);
        end
        finish_test("scrolled beams");

        // Flip and non-flip sets differ in every page nibble
        pg = rand16();
        write_reg({`SCR_REGION, REG_OFS[0]}, {2{pg}}, 4'hf, 0);
        write_reg({`SCR_REGION, REG_OFS[1]}, {2{pg ^ 16'h5555}}, 4'hf, 0);
        pg = rand16();
        write_reg({`SCR_REGION, REG_OFS[2]}, {2{pg}}, 4'hf, 0);
        write_reg({`SCR_REGION, REG_OFS[3]}, {2{pg ^ 16'h5555}}, 4'hf, 0);
        for (idx = 0; idx < 4; idx++) begin
            flip = idx[0];
            repeat (2) begin
                @(posedge clk);
                #1;
            end
            run_beams(N_BEAMS);
        end
        finish_test("flip page select");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, total_errors());
        if (total_errors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+hdl
hdl/vscroll_pkg.sv
hdl/axil_mmr_slave.sv
hdl/scroll_mmr.sv
hdl/tile_addr_gen.sv
hdl/scroll_top.sv
verif/scroll_assert.sv
verif/scroll_tb.sv
